// File: source/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;
	localparam int BUS_AW = 30; // Word address, bits [31:2] of the byte address.
	localparam int BUS_DW = 32;
	localparam int BUS_BW = BUS_DW / 8;

	// Default processor-side windows in byte addresses.
	// 32 MiB of SDRAM, then a single control word well away from it.
	localparam logic [BUS_AW+1:0] MEM_BASE_DEF = 32'h2000_0000;
	localparam logic [BUS_AW+1:0] MEM_SIZE_DEF = 32'h0200_0000;
	localparam logic [BUS_AW+1:0] CTRL_BASE_DEF = 32'h8000_2000;
	localparam logic [BUS_AW+1:0] CTRL_SIZE_DEF = 32'h0000_0004;
endpackage

`default_nettype wire

// File: source/sdram_pkg.sv
`default_nettype none

package sdram_pkg;
	localparam int SD_DW = 16;
	localparam int SD_ROW_W = 13;
	localparam int SD_COL_W = 9;
	localparam int SD_BANK_W = 2;

	// Pin pattern {cs_n, ras_n, cas_n, we_n}.
	typedef enum logic [3:0] {
		NOP = 4'b0111,
		ACTIVE = 4'b0011,
		READ = 4'b0101,
		WRITE = 4'b0100,
		PRECHARGE = 4'b0010,
		REFRESH = 4'b0001,
		LOAD_MODE = 4'b0000
	} sd_cmd_t;

	localparam int T_RCD = 2;
	localparam int T_RP = 2;
	localparam int T_RFC = 7;
	localparam int CAS_LAT = 2;

	// Burst length 1, sequential order, standard operation.
	localparam logic [SD_ROW_W-1:0] MODE_WORD = {6'b0, 3'(CAS_LAT), 1'b0, 3'b000};
endpackage

`default_nettype wire

// File: source/region_decode.sv
`timescale 1ns/1ps
`default_nettype none

module region_decode import mem_map_pkg::*; #(
	parameter logic [BUS_AW+1:0] BASE = '0,
	parameter logic [BUS_AW+1:0] SIZE = '0
) (
	input wire [BUS_AW-1:0] i_addr,
	output logic o_hit
);
	// One bit wider so that a window ending at the top of the map does not wrap.
	localparam logic [BUS_AW+2:0] LIMIT = {1'b0, BASE} + {1'b0, SIZE};

	logic [BUS_AW+2:0] byte_addr;

	assign byte_addr = {1'b0, i_addr, 2'b00};
	assign o_hit = (SIZE != '0) && (byte_addr >= {1'b0, BASE}) && (byte_addr < LIMIT);
endmodule

`default_nettype wire

// File: source/sdram_bus_mux.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_bus_mux import mem_map_pkg::*; #(
	parameter logic [BUS_AW+1:0] MEM_BASE = MEM_BASE_DEF,
	parameter logic [BUS_AW+1:0] MEM_SIZE = MEM_SIZE_DEF,
	parameter logic [BUS_AW+1:0] CTRL_BASE = CTRL_BASE_DEF,
	parameter logic [BUS_AW+1:0] CTRL_SIZE = CTRL_SIZE_DEF
) (
	input wire clk,
	input wire i_rst_n,
	input wire i_d_access,
	input wire [BUS_AW-1:0] i_d_addr,
	input wire [BUS_DW-1:0] i_d_wr_val,
	input wire i_d_wr_en,
	input wire [BUS_BW-1:0] i_d_bytesel,
	output wire o_d_cs,
	output wire o_ctrl_cs,
	output logic o_d_ack,
	output logic [BUS_DW-1:0] o_d_data,
	input wire i_i_access,
	input wire [BUS_AW-1:0] i_i_addr,
	output wire o_i_cs,
	output logic o_i_ack,
	output logic [BUS_DW-1:0] o_i_data,
	input wire i_config_done,
	output logic o_h_cs,
	output logic [BUS_AW-1:0] o_h_addr,
	output logic [BUS_DW-1:0] o_h_wdata,
	output logic o_h_wr_en,
	output logic [BUS_BW-1:0] o_h_bytesel,
	input wire [BUS_DW-1:0] i_h_rdata,
	input wire i_h_compl
);
	logic d_busy;
	logic i_busy;
	logic d_sel;
	logic i_sel;
	logic ctrl_ack;
	logic ctrl_bit;

	region_decode #(.BASE(MEM_BASE), .SIZE(MEM_SIZE)) d_mem_decode (.i_addr(i_d_addr), .o_hit(o_d_cs));
	region_decode #(.BASE(MEM_BASE), .SIZE(MEM_SIZE)) i_mem_decode (.i_addr(i_i_addr), .o_hit(o_i_cs));
	region_decode #(.BASE(CTRL_BASE), .SIZE(CTRL_SIZE)) ctrl_decode (.i_addr(i_d_addr), .o_hit(o_ctrl_cs));

	// Data wins a tie, but a fetch already in the bridge is allowed to finish.
	assign d_sel = d_busy | (i_d_access & o_d_cs & ~i_busy);
	assign i_sel = ~d_sel & (i_busy | (i_i_access & o_i_cs));

	assign o_h_cs = d_sel | i_sel;
	assign o_h_addr = d_sel ? i_d_addr : i_i_addr;
	assign o_h_wdata = i_d_wr_val;
	assign o_h_wr_en = d_sel & i_d_wr_en; // Fetches are always reads.
	assign o_h_bytesel = d_sel ? i_d_bytesel : {BUS_BW{1'b1}};

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			d_busy <= 1'b0;
			i_busy <= 1'b0;
			ctrl_ack <= 1'b0;
		end else begin
			d_busy <= d_sel & ~i_h_compl;
			i_busy <= i_sel & ~i_h_compl;
			ctrl_ack <= i_d_access & o_ctrl_cs & ~ctrl_ack; // The master is still holding access during the ack.
		end
	end

	always_ff @(posedge clk)
		ctrl_bit <= i_config_done;

	assign o_d_ack = ctrl_ack | (d_busy & i_h_compl);
	assign o_i_ack = i_busy & i_h_compl;
	assign o_i_data = o_i_ack ? i_h_rdata : '0;

	always_comb begin
		if (ctrl_ack)
			o_d_data = {{(BUS_DW-1){1'b0}}, ctrl_bit};
		else if (d_busy & i_h_compl)
			o_d_data = i_h_rdata;
		else
			o_d_data = '0;
	end

	// Each bridge completion belongs to exactly one bus that was granted before it.
	assert property (@(posedge clk) disable iff (!i_rst_n) i_h_compl |-> $onehot({d_busy, i_busy}))
		else $error("host completion without a single owner");
endmodule

`default_nettype wire

// File: source/bus_bridge_32_16.sv
`timescale 1ns/1ps
`default_nettype none

module bus_bridge_32_16 import mem_map_pkg::*; (
	input wire clk,
	input wire i_rst_n,
	input wire i_h_cs,
	input wire [BUS_AW-1:0] i_h_addr,
	input wire [BUS_DW-1:0] i_h_wdata,
	input wire i_h_wr_en,
	input wire [BUS_BW-1:0] i_h_bytesel,
	output logic [BUS_DW-1:0] o_h_rdata,
	output logic o_h_compl,
	output logic o_b_cs,
	output logic [BUS_AW:0] o_b_addr,
	output logic [BUS_DW/2-1:0] o_b_wdata,
	output logic o_b_wr_en,
	output logic [BUS_BW/2-1:0] o_b_bytesel,
	input wire [BUS_DW/2-1:0] i_b_rdata,
	input wire i_b_compl
);
	localparam int HW = BUS_DW / 2;
	localparam int HB = BUS_BW / 2;

	typedef enum logic [1:0] {BR_IDLE, BR_LO, BR_HI, BR_DONE} state_t;

	state_t state;
	logic lo_en;
	logic hi_en;

	assign lo_en = |i_h_bytesel[HB-1:0];
	assign hi_en = |i_h_bytesel[BUS_BW-1:HB];
	assign o_h_compl = state == BR_DONE;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state <= BR_IDLE;
			o_b_cs <= 1'b0;
		end else begin
			case (state)
			BR_IDLE: if (i_h_cs) begin
				o_h_rdata <= '0; // Skipped halves read as zero.
				o_b_wr_en <= i_h_wr_en;
				if (lo_en) begin
					o_b_cs <= 1'b1;
					o_b_addr <= {i_h_addr, 1'b0};
					o_b_wdata <= i_h_wdata[HW-1:0];
					o_b_bytesel <= i_h_bytesel[HB-1:0];
					state <= BR_LO;
				end else if (hi_en) begin
					o_b_cs <= 1'b1;
					o_b_addr <= {i_h_addr, 1'b1};
					o_b_wdata <= i_h_wdata[BUS_DW-1:HW];
					o_b_bytesel <= i_h_bytesel[BUS_BW-1:HB];
					state <= BR_HI;
				end else begin
					state <= BR_DONE;
				end
			end
			BR_LO: if (i_b_compl) begin
				o_h_rdata[HW-1:0] <= i_b_rdata;
				if (hi_en) begin
					o_b_addr <= {i_h_addr, 1'b1}; // Chip select stays up for the second half.
					o_b_wdata <= i_h_wdata[BUS_DW-1:HW];
					o_b_bytesel <= i_h_bytesel[BUS_BW-1:HB];
					state <= BR_HI;
				end else begin
					o_b_cs <= 1'b0;
					state <= BR_DONE;
				end
			end
			BR_HI: if (i_b_compl) begin
				o_h_rdata[BUS_DW-1:HW] <= i_b_rdata;
				o_b_cs <= 1'b0;
				state <= BR_DONE;
			end
			default: state <= BR_IDLE;
			endcase
		end
	end

	// The controller only completes a half that is still requested, and the host keeps
	// its access up until the whole word is done.
	assert property (@(posedge clk) disable iff (!i_rst_n) i_b_compl |-> o_b_cs && i_h_cs)
		else $error("half-word completion without a live request");
endmodule

`default_nettype wire

// File: source/sdram_controller.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_controller import mem_map_pkg::*, sdram_pkg::*; #(
	parameter int unsigned INIT_CYCLES = 2000,
	parameter int unsigned REFRESH_INTERVAL = 780
) (
	input wire clk,
	input wire i_rst_n,
	input wire i_b_cs,
	input wire [BUS_AW:0] i_b_addr,
	input wire [SD_DW-1:0] i_b_wdata,
	input wire i_b_wr_en,
	input wire [SD_DW/8-1:0] i_b_bytesel,
	output logic [SD_DW-1:0] o_b_rdata,
	output logic o_b_compl,
	output logic o_config_done,
	output logic o_s_cs_n,
	output logic o_s_ras_n,
	output logic o_s_cas_n,
	output logic o_s_we_n,
	output logic [SD_ROW_W-1:0] o_s_addr,
	output logic [SD_BANK_W-1:0] o_s_banksel,
	output logic [SD_DW/8-1:0] o_s_bytesel,
	output logic o_s_clken,
	inout wire [SD_DW-1:0] s_data
);
	localparam int WAIT_W = $clog2(INIT_CYCLES + T_RFC + 1);
	localparam int REF_W = $clog2(REFRESH_INTERVAL + 1);
	localparam logic [SD_ROW_W-1:0] PRE_ALL = SD_ROW_W'(1 << 10); // A10 high closes every bank.

	typedef enum logic [3:0] {
		S_WAIT, S_INIT_PRE, S_INIT_REF, S_INIT_MODE, S_IDLE, S_RW, S_CAPTURE, S_PRE, S_DONE
	} state_t;

	state_t state;
	state_t ret_state;
	logic [WAIT_W-1:0] wait_cnt;
	logic second_ref;
	logic [REF_W-1:0] refresh_cnt;
	logic refresh_due;
	sd_cmd_t s_cmd;
	logic [SD_DW-1:0] dq_out;
	logic dq_oe;
	logic [SD_COL_W-1:0] col;
	logic [SD_ROW_W-1:0] row;
	logic [SD_BANK_W-1:0] bank;

	assign col = i_b_addr[SD_COL_W-1:0];
	assign row = i_b_addr[SD_COL_W +: SD_ROW_W];
	assign bank = i_b_addr[SD_COL_W + SD_ROW_W +: SD_BANK_W];

	assign {o_s_cs_n, o_s_ras_n, o_s_cas_n, o_s_we_n} = s_cmd;
	assign o_s_clken = 1'b1;
	assign s_data = dq_oe ? dq_out : 'z;
	assign o_b_compl = state == S_DONE;

	// A command state issues for one cycle and then parks in S_WAIT, which counts T - 2
	// so that the following command lands exactly T clocks later.
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state <= S_WAIT;
			ret_state <= S_INIT_PRE;
			wait_cnt <= WAIT_W'(INIT_CYCLES);
			second_ref <= 1'b0;
			o_config_done <= 1'b0;
			s_cmd <= NOP;
			dq_oe <= 1'b0;
			refresh_cnt <= '0;
			refresh_due <= 1'b0;
		end else begin
			s_cmd <= NOP;
			dq_oe <= 1'b0;
			case (state)
			S_WAIT: begin
				if (wait_cnt == '0)
					state <= ret_state;
				else
					wait_cnt <= wait_cnt - 1'b1;
			end
			S_INIT_PRE: begin
				s_cmd <= PRECHARGE;
				o_s_addr <= PRE_ALL;
				wait_cnt <= WAIT_W'(T_RP - 2);
				ret_state <= S_INIT_REF;
				state <= S_WAIT;
			end
			S_INIT_REF: begin
				s_cmd <= REFRESH;
				wait_cnt <= WAIT_W'(T_RFC - 2);
				ret_state <= second_ref ? S_INIT_MODE : S_INIT_REF;
				second_ref <= 1'b1;
				state <= S_WAIT;
			end
			S_INIT_MODE: begin
				s_cmd <= LOAD_MODE;
				o_s_addr <= MODE_WORD;
				o_s_banksel <= '0;
				o_config_done <= 1'b1;
				wait_cnt <= '0;
				ret_state <= S_IDLE;
				state <= S_WAIT;
			end
			S_IDLE: begin
				if (refresh_due) begin
					s_cmd <= REFRESH;
					refresh_due <= 1'b0;
					wait_cnt <= WAIT_W'(T_RFC - 2);
					ret_state <= S_IDLE;
					state <= S_WAIT;
				end else if (i_b_cs) begin
					s_cmd <= ACTIVE;
					o_s_addr <= row;
					o_s_banksel <= bank;
					wait_cnt <= WAIT_W'(T_RCD - 2);
					ret_state <= S_RW;
					state <= S_WAIT;
				end
			end
			S_RW: begin
				o_s_addr <= SD_ROW_W'(col); // A10 low, no auto precharge.
				if (i_b_wr_en) begin
					s_cmd <= WRITE;
					dq_out <= i_b_wdata;
					dq_oe <= 1'b1;
					o_s_bytesel <= ~i_b_bytesel;
					wait_cnt <= '0; // Gives two clocks of write recovery.
					ret_state <= S_PRE;
				end else begin
					s_cmd <= READ;
					o_s_bytesel <= '0;
					wait_cnt <= WAIT_W'(CAS_LAT - 1);
					ret_state <= S_CAPTURE;
				end
				state <= S_WAIT;
			end
			S_CAPTURE: begin
				o_b_rdata <= s_data;
				state <= S_PRE;
			end
			S_PRE: begin
				s_cmd <= PRECHARGE;
				o_s_addr <= PRE_ALL;
				wait_cnt <= WAIT_W'(T_RP - 2);
				ret_state <= S_DONE;
				state <= S_WAIT;
			end
			default: state <= S_IDLE;
			endcase

			// Placed after the FSM so that a refresh falling due in the same cycle is kept.
			if (refresh_cnt == REF_W'(REFRESH_INTERVAL - 1)) begin
				refresh_cnt <= '0;
				refresh_due <= 1'b1;
			end else begin
				refresh_cnt <= refresh_cnt + 1'b1;
			end
		end
	end

	// Every column command comes T_RCD after its ACTIVE and only once the chip is set up.
	assert property (@(posedge clk) disable iff (!i_rst_n)
		(s_cmd inside {READ, WRITE}) |-> o_config_done && $past(s_cmd, T_RCD) == ACTIVE)
		else $error("column command without a timed ACTIVE");
endmodule

`default_nettype wire

// File: source/sdram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_subsystem import mem_map_pkg::*, sdram_pkg::*; #(
	parameter logic [BUS_AW+1:0] MEM_BASE = MEM_BASE_DEF,
	parameter logic [BUS_AW+1:0] MEM_SIZE = MEM_SIZE_DEF,
	parameter logic [BUS_AW+1:0] CTRL_BASE = CTRL_BASE_DEF,
	parameter logic [BUS_AW+1:0] CTRL_SIZE = CTRL_SIZE_DEF,
	parameter int unsigned INIT_CYCLES = 2000,
	parameter int unsigned REFRESH_INTERVAL = 780
) (
	input wire clk,
	input wire i_rst_n,
	input wire i_d_access,
	input wire [BUS_AW-1:0] i_d_addr,
	input wire [BUS_DW-1:0] i_d_wr_val,
	input wire i_d_wr_en,
	input wire [BUS_BW-1:0] i_d_bytesel,
	output wire o_d_cs,
	output wire o_ctrl_cs,
	output wire o_d_ack,
	output wire [BUS_DW-1:0] o_d_data,
	input wire i_i_access,
	input wire [BUS_AW-1:0] i_i_addr,
	output wire o_i_cs,
	output wire o_i_ack,
	output wire [BUS_DW-1:0] o_i_data,
	output wire o_s_cs_n,
	output wire o_s_ras_n,
	output wire o_s_cas_n,
	output wire o_s_we_n,
	output wire [SD_ROW_W-1:0] o_s_addr,
	output wire [SD_BANK_W-1:0] o_s_banksel,
	output wire [SD_DW/8-1:0] o_s_bytesel,
	output wire o_s_clken,
	inout wire [SD_DW-1:0] s_data
);
	wire h_cs;
	wire [BUS_AW-1:0] h_addr;
	wire [BUS_DW-1:0] h_wdata;
	wire h_wr_en;
	wire [BUS_BW-1:0] h_bytesel;
	wire [BUS_DW-1:0] h_rdata;
	wire h_compl;
	wire b_cs;
	wire [BUS_AW:0] b_addr; // Half-word address.
	wire [SD_DW-1:0] b_wdata;
	wire b_wr_en;
	wire [SD_DW/8-1:0] b_bytesel;
	wire [SD_DW-1:0] b_rdata;
	wire b_compl;
	wire config_done;

	sdram_bus_mux #(
		.MEM_BASE(MEM_BASE),
		.MEM_SIZE(MEM_SIZE),
		.CTRL_BASE(CTRL_BASE),
		.CTRL_SIZE(CTRL_SIZE)
	) bus_mux_i (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_d_access(i_d_access), .i_d_addr(i_d_addr), .i_d_wr_val(i_d_wr_val),
		.i_d_wr_en(i_d_wr_en), .i_d_bytesel(i_d_bytesel), .o_d_cs(o_d_cs),
		.o_ctrl_cs(o_ctrl_cs), .o_d_ack(o_d_ack), .o_d_data(o_d_data),
		.i_i_access(i_i_access), .i_i_addr(i_i_addr), .o_i_cs(o_i_cs),
		.o_i_ack(o_i_ack), .o_i_data(o_i_data), .i_config_done(config_done),
		.o_h_cs(h_cs), .o_h_addr(h_addr), .o_h_wdata(h_wdata), .o_h_wr_en(h_wr_en),
		.o_h_bytesel(h_bytesel), .i_h_rdata(h_rdata), .i_h_compl(h_compl)
	);

	bus_bridge_32_16 bridge_i (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_h_cs(h_cs), .i_h_addr(h_addr), .i_h_wdata(h_wdata), .i_h_wr_en(h_wr_en),
		.i_h_bytesel(h_bytesel), .o_h_rdata(h_rdata), .o_h_compl(h_compl),
		.o_b_cs(b_cs), .o_b_addr(b_addr), .o_b_wdata(b_wdata), .o_b_wr_en(b_wr_en),
		.o_b_bytesel(b_bytesel), .i_b_rdata(b_rdata), .i_b_compl(b_compl)
	);

	sdram_controller #(
		.INIT_CYCLES(INIT_CYCLES),
		.REFRESH_INTERVAL(REFRESH_INTERVAL)
	) controller_i (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_b_cs(b_cs), .i_b_addr(b_addr), .i_b_wdata(b_wdata), .i_b_wr_en(b_wr_en),
		.i_b_bytesel(b_bytesel), .o_b_rdata(b_rdata), .o_b_compl(b_compl),
		.o_config_done(config_done),
		.o_s_cs_n(o_s_cs_n), .o_s_ras_n(o_s_ras_n), .o_s_cas_n(o_s_cas_n),
		.o_s_we_n(o_s_we_n), .o_s_addr(o_s_addr), .o_s_banksel(o_s_banksel),
		.o_s_bytesel(o_s_bytesel), .o_s_clken(o_s_clken), .s_data(s_data)
	);
endmodule

`default_nettype wire

// File: dv/sdram_chip_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_chip_model import sdram_pkg::*; (
	input wire clk,
	input wire i_cs_n,
	input wire i_ras_n,
	input wire i_cas_n,
	input wire i_we_n,
	input wire [SD_ROW_W-1:0] i_addr,
	input wire [SD_BANK_W-1:0] i_banksel,
	input wire [SD_DW/8-1:0] i_dqm,
	inout wire [SD_DW-1:0] dq
);
	logic [SD_DW-1:0] mem [int unsigned];
	logic [SD_ROW_W-1:0] open_row [1 << SD_BANK_W];
	logic [CAS_LAT-1:0] rd_valid = '0;
	logic [SD_DW-1:0] rd_data [CAS_LAT];
	sd_cmd_t cmd;

	assign cmd = sd_cmd_t'({i_cs_n, i_ras_n, i_cas_n, i_we_n});
	assign dq = rd_valid[CAS_LAT-1] ? rd_data[CAS_LAT-1] : 'z; // Data leaves CAS_LAT clocks after READ.

	function automatic int unsigned cell_index(input logic [SD_BANK_W-1:0] bank,
			input logic [SD_COL_W-1:0] col);
		return {bank, open_row[bank], col};
	endfunction

	always @(posedge clk) begin
		int unsigned idx;
		logic [SD_DW-1:0] word;

		rd_valid <= {rd_valid[CAS_LAT-2:0], 1'b0};
		for (int i = 1; i < CAS_LAT; i++)
			rd_data[i] <= rd_data[i-1];
		idx = cell_index(i_banksel, i_addr[SD_COL_W-1:0]);
		case (cmd)
		ACTIVE: open_row[i_banksel] <= i_addr;
		READ: begin
			rd_valid[0] <= 1'b1;
			rd_data[0] <= mem.exists(idx) ? mem[idx] : '0;
		end
		WRITE: begin
			word = mem.exists(idx) ? mem[idx] : '0;
			for (int b = 0; b < SD_DW / 8; b++)
				if (!i_dqm[b])
					word[8*b +: 8] = dq[8*b +: 8]; // A high mask bit protects its byte.
			mem[idx] = word;
		end
		default: ;
		endcase
	end
endmodule

`default_nettype wire

// File: dv/tb_sdram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_subsystem import mem_map_pkg::*, sdram_pkg::*;;
	localparam int INIT_CYCLES = 20;
	localparam int REFRESH_INTERVAL = 200;
	localparam logic [BUS_AW-1:0] MEM_W = BUS_AW'(MEM_BASE_DEF >> 2);
	localparam logic [BUS_AW-1:0] MEM_WORDS = BUS_AW'(MEM_SIZE_DEF >> 2);
	localparam logic [BUS_AW-1:0] CTRL_W = BUS_AW'(CTRL_BASE_DEF >> 2);
	localparam logic [1:0] BUS_D = 2'd0, BUS_I = 2'd1, BUS_BOTH = 2'd2, BUS_IDLE = 2'd3;

	typedef struct packed {
		logic [1:0] bus;
		logic [BUS_AW-1:0] addr;
		logic wr;
		logic chk;
		logic [31:0] data; // Idle rows keep their length in clocks here.
		logic [3:0] bsel;
		logic [31:0] exp;
	} row_t;

	logic clk = 1'b0;
	logic i_rst_n;
	logic i_d_access, i_d_wr_en, i_i_access;
	logic [BUS_AW-1:0] i_d_addr, i_i_addr;
	logic [31:0] i_d_wr_val;
	logic [3:0] i_d_bytesel;
	wire o_d_cs, o_ctrl_cs, o_d_ack, o_i_cs, o_i_ack;
	wire [31:0] o_d_data, o_i_data;
	wire o_s_cs_n, o_s_ras_n, o_s_cas_n, o_s_we_n, o_s_clken;
	wire [SD_ROW_W-1:0] o_s_addr;
	wire [SD_BANK_W-1:0] o_s_banksel;
	wire [SD_DW/8-1:0] o_s_bytesel;
	wire [SD_DW-1:0] s_data;

	row_t table_q[$];
	logic [31:0] ref_mem [int unsigned];
	int err_count = 0;
	int cycle_cnt = 0;
	int timeout_limit = 0;

	sdram_subsystem #(
		.INIT_CYCLES(INIT_CYCLES),
		.REFRESH_INTERVAL(REFRESH_INTERVAL)
	) sdram_subsystem_i (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_d_access(i_d_access), .i_d_addr(i_d_addr), .i_d_wr_val(i_d_wr_val),
		.i_d_wr_en(i_d_wr_en), .i_d_bytesel(i_d_bytesel), .o_d_cs(o_d_cs),
		.o_ctrl_cs(o_ctrl_cs), .o_d_ack(o_d_ack), .o_d_data(o_d_data),
		.i_i_access(i_i_access), .i_i_addr(i_i_addr), .o_i_cs(o_i_cs),
		.o_i_ack(o_i_ack), .o_i_data(o_i_data),
		.o_s_cs_n(o_s_cs_n), .o_s_ras_n(o_s_ras_n), .o_s_cas_n(o_s_cas_n),
		.o_s_we_n(o_s_we_n), .o_s_addr(o_s_addr), .o_s_banksel(o_s_banksel),
		.o_s_bytesel(o_s_bytesel), .o_s_clken(o_s_clken), .s_data(s_data)
	);

	sdram_chip_model chip_i (
		.clk(clk), .i_cs_n(o_s_cs_n), .i_ras_n(o_s_ras_n), .i_cas_n(o_s_cas_n),
		.i_we_n(o_s_we_n), .i_addr(o_s_addr), .i_banksel(o_s_banksel),
		.i_dqm(o_s_bytesel), .dq(s_data)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt++;
		if (timeout_limit > 0 && cycle_cnt > timeout_limit) begin
			$display("Timeout: no acknowledge after %0d clock cycles", cycle_cnt);
			$display("Test failed");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "stopping at the first error");
		end
	endtask

	function automatic bit in_mem_window(input logic [BUS_AW-1:0] addr);
		return addr >= MEM_W && addr < MEM_W + MEM_WORDS;
	endfunction

	// Address decodes of the buses that a row drives.
	task automatic check_decode(input row_t r);
		if (r.bus != BUS_I) begin
			check_value("data memory select", o_d_cs, in_mem_window(r.addr));
			check_value("control register select", o_ctrl_cs, r.addr == CTRL_W);
		end
		if (r.bus != BUS_D)
			check_value("instruction memory select", o_i_cs, in_mem_window(r.addr));
	endtask

	function automatic logic [31:0] ref_read(input logic [BUS_AW-1:0] addr);
		return ref_mem.exists(addr) ? ref_mem[addr] : 32'h0;
	endfunction

	task automatic add_write(input logic [BUS_AW-1:0] addr, input logic [31:0] data,
			input logic [3:0] bsel);
		logic [31:0] word;

		word = ref_read(addr);
		for (int b = 0; b < 4; b++)
			if (bsel[b])
				word[8*b +: 8] = data[8*b +: 8];
		ref_mem[addr] = word; // Only selected bytes change.
		table_q.push_back('{BUS_D, addr, 1'b1, 1'b0, data, bsel, 32'h0});
	endtask

	task automatic add_read(input logic [1:0] bus, input logic [BUS_AW-1:0] addr);
		table_q.push_back('{bus, addr, 1'b0, 1'b1, 32'h0, 4'hf, ref_read(addr)});
	endtask

	task automatic build_table();
		int offs[7] = '{0, 1, 'h100, 'h20_0000, 'h40_0000, 'h60_0123, 'h7f_ffff};
		logic [3:0] masks[5] = '{4'b0001, 4'b0100, 4'b1100, 4'b0011, 4'b1010};

		foreach (offs[k])
			add_write(MEM_W + BUS_AW'(offs[k]), $urandom, 4'hf);
		foreach (offs[k])
			add_read(BUS_D, MEM_W + BUS_AW'(offs[k]));
		add_write(MEM_W + 2, $urandom, 4'hf);
		foreach (masks[k]) begin
			add_write(MEM_W + 2, $urandom, masks[k]);
			add_read(BUS_D, MEM_W + 2);
		end
		foreach (offs[k])
			add_read(BUS_I, MEM_W + BUS_AW'(offs[k]));
		add_read(BUS_BOTH, MEM_W + BUS_AW'(offs[1]));
		add_read(BUS_BOTH, MEM_W + BUS_AW'(offs[4]));
		table_q.push_back('{BUS_D, CTRL_W, 1'b1, 1'b0, 32'h0, 4'hf, 32'h0}); // Ignored write.
		table_q.push_back('{BUS_D, CTRL_W, 1'b0, 1'b1, 32'h0, 4'hf, 32'h1});
		table_q.push_back('{BUS_IDLE, '0, 1'b0, 1'b0, REFRESH_INTERVAL + 50, 4'h0, 32'h0});
		foreach (offs[k])
			add_read(BUS_D, MEM_W + BUS_AW'(offs[k]));
		add_read(BUS_D, MEM_W + 2);
	endtask

	task automatic run_row(input row_t r, output logic [31:0] d_got);
		bit d_done;
		bit i_done;
		int n;

		@(posedge clk);
		#10;
		if (r.bus == BUS_IDLE) begin
			repeat (r.data) @(posedge clk);
			return;
		end
		d_done = (r.bus == BUS_I);
		i_done = (r.bus == BUS_D);
		if (!d_done) begin
			i_d_access = 1'b1;
			i_d_addr = r.addr;
			i_d_wr_en = r.wr;
			i_d_wr_val = r.data;
			i_d_bytesel = r.bsel;
		end
		if (!i_done) begin
			i_i_access = 1'b1;
			i_i_addr = r.addr;
		end
		n = 0;
		while (!(d_done && i_done)) begin
			@(posedge clk);
			#10;
			n++;
			if (n == 1)
				check_decode(r);
			if (d_done)
				i_d_access = 1'b0; // Released the cycle after its ack.
			if (o_d_ack) begin
				check_value("data ack without a pending data access", d_done, 0);
				d_got = o_d_data;
				if (r.chk)
					check_value("data read", o_d_data, r.exp);
				if (r.addr == CTRL_W)
					check_value("control register ack latency", n, 1);
				d_done = 1'b1;
			end
			if (o_i_ack) begin
				check_value("fetch ack without a pending fetch", i_done, 0);
				check_value("data access acknowledged before the fetch", d_done, 1);
				check_value("instruction fetch", o_i_data, r.exp);
				i_done = 1'b1;
			end
		end
		@(posedge clk);
		#10;
		i_d_access = 1'b0;
		i_i_access = 1'b0;
	endtask

	initial begin
		logic [31:0] got;
		bit seen_done;
		int extra;
		row_t poll;

		void'($urandom(32'hccb6));
		i_rst_n = 1'b0;
		i_d_access = 1'b0;
		i_d_addr = '0;
		i_d_wr_val = '0;
		i_d_wr_en = 1'b0;
		i_d_bytesel = '0;
		i_i_access = 1'b0;
		i_i_addr = '0;
		build_table();
		timeout_limit = 4 * INIT_CYCLES + table_q.size() * 40 + REFRESH_INTERVAL + 500;
		repeat (2) @(posedge clk);
		#10;
		i_rst_n = 1'b1;
		check_value("SDRAM clock enable", o_s_clken, 1);

		// Poll until the controller reports that the chip is set up.
		poll = '{BUS_D, CTRL_W, 1'b0, 1'b0, 32'h0, 4'hf, 32'h0};
		seen_done = 1'b0;
		extra = 0;
		for (int k = 0; k < 200 && extra < 3; k++) begin
			run_row(poll, got);
			if (k == 0)
				check_value("first control poll", got, 0);
			if (!seen_done && got !== 32'h1)
				check_value("control poll before set up", got, 0);
			if (seen_done) begin
				check_value("control poll after set up", got, 1);
				extra++;
			end
			if (got == 32'h1)
				seen_done = 1'b1;
		end
		check_value("initialisation finished", seen_done, 1);

		foreach (table_q[k])
			run_row(table_q[k], got);

		if (err_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end
endmodule

`default_nettype wire

// File: build.f
source/mem_map_pkg.sv
source/sdram_pkg.sv
source/region_decode.sv
source/sdram_bus_mux.sv
source/bus_bridge_32_16.sv
source/sdram_controller.sv
source/sdram_subsystem.sv
dv/sdram_chip_model.sv
dv/tb_sdram_subsystem.sv
